// ==== include/vic20_load_cfg.svh ====
// VIC-20 loader constants for download indices, load bases and sequencer limits
`ifndef VIC20_LOAD_CFG_SVH
`define VIC20_LOAD_CFG_SVH

// ============================================================
// Download index values from the host
// ============================================================

// System ROM image (kernal, basic, character)
`define DL_IDX_ROM 8'h00
// Program file with a two-byte load address header
`define DL_IDX_PRG 8'h01
// Cartridge image, handled like a PRG
`define DL_IDX_CRT 8'h41
// Tape image
`define DL_IDX_TAP 8'h81

// ============================================================
// Load addresses
// ============================================================

// PRG base when the header is not used
`define CRT_BASE_ADDR 16'hA000
// TAP images live above the core RAM in SDRAM
`define TAP_BASE_ADDR 23'h20000
// Cleared on cart unload so the kernal finds no signature
`define CART_UNLOAD_ADDR 16'hA004

// Last step of the BASIC pointer sequence
`define INJECT_LAST_STEP 5'd31

`endif

// ==== hdl/vic20_load_pkg.sv ====
// Shared bus and request types for the VIC-20 file loader
package vic20_load_pkg;

    // ============================================================
    // Host download stream
    // ============================================================

    typedef struct packed {
        logic        active;
        logic [7:0]  index;
        logic        wr;
        // Byte offset within the file
        logic [24:0] addr;
        logic [7:0]  data;
    } dl_bus_t;

    typedef enum logic [1:0] {
        NONE = 2'd0,
        ROM  = 2'd1,
        PRG  = 2'd2,
        TAP  = 2'd3
    } dl_kind_t;

    // ============================================================
    // Memory side requests
    // ============================================================

    // Core external memory access, wr_n low means write
    typedef struct packed {
        logic        sel;
        logic        wr_n;
        logic [15:0] addr;
        logic [7:0]  data;
    } core_mem_t;

    typedef struct packed {
        logic        we;
        logic        oe;
        logic [22:0] addr;
        logic [7:0]  din;
    } sdram_req_t;

    // Write into core internal RAM/ROM
    typedef struct packed {
        logic        wr;
        logic [15:0] addr;
        logic [7:0]  data;
    } conf_wr_t;

    typedef struct packed {
        logic        busy;
        logic [15:0] addr;
        logic [7:0]  data;
    } inject_t;

endpackage

// ==== hdl/load_addr_map.sv ====
// Download kind decode, target address mapping and internal memory classification
`timescale 1ns/10ps
`include "vic20_load_cfg.svh"

module load_addr_map (
    input  vic20_load_pkg::dl_bus_t  dl_i,
    input  logic [15:0]              prg_addr_i,
    input  logic [22:0]              tap_addr_i,
    input  vic20_load_pkg::inject_t  inject_i,
    output vic20_load_pkg::dl_kind_t kind_o,
    output logic [22:0]              target_addr_o,
    output logic                     internal_o
);

    import vic20_load_pkg::*;

    logic [22:0] rom_addr;
    logic        prg_internal;

    // Kind of the running download
    always_comb begin
        kind_o = NONE;
        if (dl_i.active) begin
            case (dl_i.index)
                `DL_IDX_ROM: kind_o = ROM;
                `DL_IDX_PRG,
                `DL_IDX_CRT: kind_o = PRG;
                `DL_IDX_TAP: kind_o = TAP;
                default:     kind_o = NONE;
            endcase
        end
    end

    // ROM file layout with offsets below $2000 dropped
    always_comb begin
        rom_addr = '0;
        if (dl_i.addr[24:15] == '0) begin
            case (dl_i.addr[14:13])
                // Kernal
                2'b01:   rom_addr = {7'h00, 3'b111, dl_i.addr[12:0]};
                // Basic
                2'b10:   rom_addr = {7'h00, 3'b110, dl_i.addr[12:0]};
                // 4K character set
                2'b11:   rom_addr = {7'h00, 4'b1000, dl_i.addr[11:0]};
                default: rom_addr = '0;
            endcase
        end
    end

    // Internal RAM covers zero page and stack, the $1000 block and colour RAM
    assign prg_internal = (prg_addr_i[15:10] == 6'b000000) ||
                          (prg_addr_i[15:12] == 4'b0001)   ||
                          (prg_addr_i[15:10] == 6'b100101);

    always_comb begin
        case (kind_o)
            ROM: begin
                target_addr_o = rom_addr;
                internal_o    = target_addr_o[15:14] != 2'b00;
            end
            TAP: begin
                target_addr_o = tap_addr_i;
                internal_o    = 1'b0;
            end
            default: begin
                // Pointer writes take over the PRG path once the file is done
                if (inject_i.busy) begin
                    target_addr_o = {7'h00, inject_i.addr};
                    internal_o    = 1'b1;
                end else begin
                    target_addr_o = {7'h00, prg_addr_i};
                    internal_o    = (kind_o == PRG) && prg_internal;
                end
            end
        endcase
    end

endmodule

// ==== hdl/prg_load_tracker.sv ====
// Running PRG/TAP load addresses, header capture and the per-byte write pulse
`timescale 1ns/10ps
`include "vic20_load_cfg.svh"

module prg_load_tracker (
    input  logic                     clk_sys,
    input  logic                     rst_i,
    input  vic20_load_pkg::dl_bus_t  dl_i,
    input  vic20_load_pkg::dl_kind_t kind_i,
    input  logic                     crt_no_load_addr_i,
    output logic [15:0]              prg_addr_o,
    output logic [22:0]              tap_addr_o,
    output logic                     mem_wr_o,
    output logic                     auto_reset_o,
    input  logic                     auto_reset_clr_i
);

    import vic20_load_pkg::*;

    logic        prg_strobe;
    logic        tap_strobe;
    logic        rom_strobe;
    logic        first_byte;
    logic        prg_store;
    logic [15:0] prg_byte_addr;
    logic [22:0] tap_byte_addr;
    logic        prg_wr_q;
    logic        tap_wr_q;

    assign prg_strobe = dl_i.wr && (kind_i == PRG);
    assign tap_strobe = dl_i.wr && (kind_i == TAP);
    assign first_byte = dl_i.addr == 25'd0;
    // Only the kernal, basic and character ranges of a ROM file are kept
    assign rom_strobe = dl_i.wr && (kind_i == ROM) &&
                        (dl_i.addr[24:15] == '0) && (dl_i.addr[14:13] != 2'b00);

    // Address of the current PRG byte, header bytes are not stored
    always_comb begin
        prg_store     = 1'b0;
        prg_byte_addr = prg_addr_o;
        if (crt_no_load_addr_i) begin
            prg_store = 1'b1;
            if (first_byte)
                prg_byte_addr = `CRT_BASE_ADDR;
        end else if (dl_i.addr > 25'd1) begin
            prg_store = 1'b1;
        end
    end

    assign tap_byte_addr = first_byte ? `TAP_BASE_ADDR : tap_addr_o;

    // ============================================================
    // Load address counters
    // ============================================================

    // Advance after the write so the pulse cycle still sees this byte's address
    always_ff @(posedge clk_sys) begin
        if (prg_strobe) begin
            if (!crt_no_load_addr_i && first_byte)
                prg_addr_o[7:0] <= dl_i.data;
            else if (!crt_no_load_addr_i && dl_i.addr == 25'd1)
                prg_addr_o[15:8] <= dl_i.data;
            else
                prg_addr_o <= prg_byte_addr;
        end else if (prg_wr_q) begin
            prg_addr_o <= prg_addr_o + 16'd1;
        end

        if (tap_strobe)
            tap_addr_o <= tap_byte_addr;
        else if (tap_wr_q)
            tap_addr_o <= tap_addr_o + 23'd1;
    end

    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            mem_wr_o     <= 1'b0;
            prg_wr_q     <= 1'b0;
            tap_wr_q     <= 1'b0;
            auto_reset_o <= 1'b0;
        end else begin
            prg_wr_q <= prg_strobe && prg_store;
            tap_wr_q <= tap_strobe;
            mem_wr_o <= (prg_strobe && prg_store) || tap_strobe || rom_strobe;
            if (auto_reset_clr_i)
                auto_reset_o <= 1'b0;
            // Cartridge area touched, reboot once loading is done
            if (prg_strobe && prg_store && prg_byte_addr == `CRT_BASE_ADDR)
                auto_reset_o <= 1'b1;
        end
    end

endmodule

// ==== hdl/basic_ptr_injector.sv ====
// Post-PRG sequencer writing the BASIC end pointers and requesting a cartridge reset
`timescale 1ns/10ps
`include "vic20_load_cfg.svh"

module basic_ptr_injector (
    input  logic                     clk_sys,
    input  logic                     rst_i,
    input  vic20_load_pkg::dl_kind_t kind_i,
    input  logic [15:0]              prg_addr_i,
    input  logic                     auto_reset_i,
    output vic20_load_pkg::inject_t  inject_o,
    output logic                     inject_wr_o,
    output logic                     auto_reset_clr_o,
    output logic                     force_reset_o
);

    import vic20_load_pkg::*;

    logic [4:0]  step_q;
    logic        prg_active;
    logic        prg_active_q;
    logic        ptr_write;
    logic        last_step;
    logic [15:0] ptr_addr;
    logic [15:0] addr_q;
    logic [7:0]  data_q;

    assign prg_active = kind_i == PRG;
    assign last_step  = step_q == `INJECT_LAST_STEP;
    // Odd steps 1..15 carry the eight pointer writes
    assign ptr_write  = step_q[0] && (step_q[4] == 1'b0);

    // VARTAB, ARYTAB, STREND and the load end pointer
    always_comb begin
        case (step_q[3:1])
            3'd0:    ptr_addr = 16'h002D;
            3'd1:    ptr_addr = 16'h002E;
            3'd2:    ptr_addr = 16'h002F;
            3'd3:    ptr_addr = 16'h0030;
            3'd4:    ptr_addr = 16'h0031;
            3'd5:    ptr_addr = 16'h0032;
            3'd6:    ptr_addr = 16'h00AE;
            default: ptr_addr = 16'h00AF;
        endcase
    end

    // ============================================================
    // Step counter
    // ============================================================

    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            step_q        <= '0;
            prg_active_q  <= 1'b0;
            inject_wr_o   <= 1'b0;
            force_reset_o <= 1'b0;
        end else begin
            prg_active_q  <= prg_active;
            inject_wr_o   <= ptr_write;
            force_reset_o <= last_step && auto_reset_i;
            if (prg_active_q && !prg_active)
                step_q <= 5'd1;
            else if (step_q != '0)
                step_q <= last_step ? 5'd0 : step_q + 5'd1;
        end
    end

    // Low byte on the even pointer index, high byte on the odd one
    always_ff @(posedge clk_sys) begin
        if (ptr_write) begin
            addr_q <= ptr_addr;
            data_q <= step_q[1] ? prg_addr_i[15:8] : prg_addr_i[7:0];
        end
    end

    assign inject_o.busy    = step_q != '0;
    assign inject_o.addr    = addr_q;
    assign inject_o.data    = data_q;
    assign auto_reset_clr_o = last_step;

endmodule

// ==== hdl/mem_port_arbiter.sv ====
// SDRAM and configuration port steering between loader, cart unload and core
`timescale 1ns/10ps
`include "vic20_load_cfg.svh"

module mem_port_arbiter (
    input  logic                       clk_sys,
    input  logic                       rst_i,
    input  vic20_load_pkg::dl_bus_t    dl_i,
    input  logic [22:0]                target_addr_i,
    input  logic                       internal_i,
    input  logic                       mem_wr_i,
    input  vic20_load_pkg::inject_t    inject_i,
    input  logic                       inject_wr_i,
    input  logic                       cart_unload_i,
    input  logic                       force_reset_i,
    input  vic20_load_pkg::core_mem_t  core_mem_i,
    output vic20_load_pkg::sdram_req_t mem_req_o,
    output vic20_load_pkg::conf_wr_t   conf_wr_o,
    output logic                       core_reset_o
);

    logic loader_owns;

    // Loader keeps the port until its last write and the pointer pass are done
    assign loader_owns = dl_i.active || mem_wr_i || inject_i.busy;

    // Internal targets never reach SDRAM
    always_comb begin
        conf_wr_o.wr   = (mem_wr_i || inject_wr_i) && internal_i;
        conf_wr_o.addr = target_addr_i[15:0];
        conf_wr_o.data = inject_i.busy ? inject_i.data : dl_i.data;
    end

    always_comb begin
        if (loader_owns) begin
            mem_req_o.we   = mem_wr_i && !internal_i;
            mem_req_o.oe   = 1'b0;
            mem_req_o.addr = target_addr_i;
            mem_req_o.din  = dl_i.data;
        end else if (cart_unload_i) begin
            // Wipe the cartridge signature byte
            mem_req_o.we   = 1'b1;
            mem_req_o.oe   = 1'b0;
            mem_req_o.addr = {7'h00, `CART_UNLOAD_ADDR};
            mem_req_o.din  = 8'h00;
        end else begin
            mem_req_o.we   = core_mem_i.sel && !core_mem_i.wr_n;
            mem_req_o.oe   = core_mem_i.sel && core_mem_i.wr_n;
            mem_req_o.addr = {7'h00, core_mem_i.addr};
            mem_req_o.din  = core_mem_i.data;
        end
    end

    // Core held in reset on system reset, cart unload or end of cartridge load
    always_ff @(posedge clk_sys) begin
        if (rst_i)
            core_reset_o <= 1'b1;
        else
            core_reset_o <= cart_unload_i || force_reset_i;
    end

endmodule

// ==== hdl/vic20_loader_top.sv ====
// VIC-20 file loader top level joining address map, tracker, injector and arbiter
`timescale 1ns/10ps

module vic20_loader_top (
    input  logic                       clk_sys,
    input  logic                       rst_i,
    input  vic20_load_pkg::dl_bus_t    dl_i,
    input  logic                       crt_no_load_addr_i,
    input  logic                       cart_unload_i,
    input  vic20_load_pkg::core_mem_t  core_mem_i,
    output vic20_load_pkg::sdram_req_t mem_req_o,
    output vic20_load_pkg::conf_wr_t   conf_wr_o,
    output logic                       core_reset_o
);

    import vic20_load_pkg::*;

    dl_kind_t    kind;
    logic [22:0] target_addr;
    logic        internal;
    logic [15:0] prg_addr;
    logic [22:0] tap_addr;
    logic        mem_wr;
    logic        auto_reset;
    logic        auto_reset_clr;
    inject_t     inject;
    logic        inject_wr;
    logic        force_reset;

    load_addr_map u_map (
        .dl_i          (dl_i),
        .prg_addr_i    (prg_addr),
        .tap_addr_i    (tap_addr),
        .inject_i      (inject),
        .kind_o        (kind),
        .target_addr_o (target_addr),
        .internal_o    (internal)
    );

    prg_load_tracker u_tracker (
        .clk_sys            (clk_sys),
        .rst_i              (rst_i),
        .dl_i               (dl_i),
        .kind_i             (kind),
        .crt_no_load_addr_i (crt_no_load_addr_i),
        .prg_addr_o         (prg_addr),
        .tap_addr_o         (tap_addr),
        .mem_wr_o           (mem_wr),
        .auto_reset_o       (auto_reset),
        .auto_reset_clr_i   (auto_reset_clr)
    );

    basic_ptr_injector u_injector (
        .clk_sys          (clk_sys),
        .rst_i            (rst_i),
        .kind_i           (kind),
        .prg_addr_i       (prg_addr),
        .auto_reset_i     (auto_reset),
        .inject_o         (inject),
        .inject_wr_o      (inject_wr),
        .auto_reset_clr_o (auto_reset_clr),
        .force_reset_o    (force_reset)
    );

    mem_port_arbiter u_arbiter (
        .clk_sys       (clk_sys),
        .rst_i         (rst_i),
        .dl_i          (dl_i),
        .target_addr_i (target_addr),
        .internal_i    (internal),
        .mem_wr_i      (mem_wr),
        .inject_i      (inject),
        .inject_wr_i   (inject_wr),
        .cart_unload_i (cart_unload_i),
        .force_reset_i (force_reset),
        .core_mem_i    (core_mem_i),
        .mem_req_o     (mem_req_o),
        .conf_wr_o     (conf_wr_o),
        .core_reset_o  (core_reset_o)
    );

endmodule

// ==== bench/vic20_loader_assert.sv ====
// Concurrent checks on memory port exclusivity and core reset, bound to the arbiter
`timescale 1ns/10ps

module vic20_loader_assert (
    input logic                       clk_sys,
    input logic                       rst_i,
    input vic20_load_pkg::sdram_req_t mem_req_i,
    input vic20_load_pkg::conf_wr_t   conf_wr_i,
    input logic                       core_reset_i
);

    int fail_count = 0;

    // SDRAM never reads and writes in the same cycle
    assert property (@(posedge clk_sys) disable iff (rst_i)
        !(mem_req_i.we && mem_req_i.oe))
        else begin
            $error("SDRAM we and oe high together");
            fail_count = fail_count + 1;
        end

    // A loader byte lands on exactly one port
    assert property (@(posedge clk_sys) disable iff (rst_i)
        !(conf_wr_i.wr && mem_req_i.we))
        else begin
            $error("Configuration write and SDRAM write in the same cycle");
            fail_count = fail_count + 1;
        end

    assert property (@(posedge clk_sys) rst_i |=> core_reset_i)
        else begin
            $error("Core reset low after system reset");
            fail_count = fail_count + 1;
        end

endmodule

bind mem_port_arbiter vic20_loader_assert u_assert (
    .clk_sys      (clk_sys),
    .rst_i        (rst_i),
    .mem_req_i    (mem_req_o),
    .conf_wr_i    (conf_wr_o),
    .core_reset_i (core_reset_o)
);

// ==== bench/tb_vic20_loader.sv ====
// Random-stimulus testbench for the VIC-20 file loader with a reference model
`timescale 1ns/10ps
`include "vic20_load_cfg.svh"

module tb_vic20_loader;

    import vic20_load_pkg::*;

    localparam int WRITE_TIMEOUT = 6;
    localparam int SEQ_TIMEOUT   = 40;

    logic        clk_sys;
    logic        rst_i;
    dl_bus_t     dl;
    logic        crt_no_load_addr;
    logic        cart_unload;
    core_mem_t   core_mem;
    sdram_req_t  mem_req;
    conf_wr_t    conf_wr;
    logic        core_reset;
    logic [31:0] header_rnd;

    integer seed;
    integer error_count;
    integer timeout_count;
    integer assert_fails;

    vic20_loader_top UUT (
        .clk_sys            (clk_sys),
        .rst_i              (rst_i),
        .dl_i               (dl),
        .crt_no_load_addr_i (crt_no_load_addr),
        .cart_unload_i      (cart_unload),
        .core_mem_i         (core_mem),
        .mem_req_o          (mem_req),
        .conf_wr_o          (conf_wr),
        .core_reset_o       (core_reset)
    );

    always #2 clk_sys = ~clk_sys;

    // ============================================================
    // Reference model
    // ============================================================

    // Kernal, basic and character image layout of a ROM file
    function automatic logic [22:0] rom_target(input logic [24:0] offset);
        logic [22:0] result;
        result = '0;
        if (offset >= 25'h2000 && offset < 25'h4000)
            result = 23'hE000 + 23'(offset - 25'h2000);
        else if (offset >= 25'h4000 && offset < 25'h6000)
            result = 23'hC000 + 23'(offset - 25'h4000);
        else if (offset >= 25'h6000 && offset < 25'h8000)
            result = 23'h8000 + 23'(offset % 25'h1000);
        return result;
    endfunction

    // Core RAM areas reached through the configuration bus
    function automatic logic prg_internal(input logic [15:0] addr);
        return (addr <= 16'h03FF) ||
               (addr >= 16'h1000 && addr <= 16'h1FFF) ||
               (addr >= 16'h9400 && addr <= 16'h97FF);
    endfunction

    function automatic logic [15:0] ptr_location(input int k);
        case (k)
            0:       return 16'h002D;
            1:       return 16'h002E;
            2:       return 16'h002F;
            3:       return 16'h0030;
            4:       return 16'h0031;
            5:       return 16'h0032;
            6:       return 16'h00AE;
            default: return 16'h00AF;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, actual, expected);
            error_count = error_count + 1;
        end
    endtask

    task automatic wait_core_reset(input logic level, output logic seen);
        integer cycles;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < SEQ_TIMEOUT) begin
            @(negedge clk_sys);
            seen   = core_reset == level;
            cycles = cycles + 1;
        end
    endtask

    // ============================================================
    // Download stimulus
    // ============================================================

    task automatic start_download(input logic [7:0] index, input logic no_hdr);
        @(posedge clk_sys);
        dl.active        <= 1'b1;
        dl.index         <= index;
        dl.addr          <= '0;
        dl.wr            <= 1'b0;
        crt_no_load_addr <= no_hdr;
        @(posedge clk_sys);
    endtask

    task automatic end_download();
        @(posedge clk_sys);
        dl.active <= 1'b0;
    endtask

    // One strobe, then wait for the resulting write on either port
    task automatic send_byte(input logic [24:0] offset, input logic [7:0] data,
                             input logic expect_wr, input logic exp_internal,
                             input logic [22:0] exp_addr);
        logic   seen;
        integer cycles;
        seen   = 1'b0;
        cycles = 0;
        @(posedge clk_sys);
        dl.addr <= offset;
        dl.data <= data;
        dl.wr   <= 1'b1;
        @(posedge clk_sys);
        dl.wr <= 1'b0;
        while (!seen && cycles < WRITE_TIMEOUT) begin
            @(negedge clk_sys);
            seen   = conf_wr.wr || mem_req.we;
            cycles = cycles + 1;
        end
        if (expect_wr && !seen) begin
            $display("Timeout: no memory write for file offset 0x%h", offset);
            timeout_count = timeout_count + 1;
        end else if (!expect_wr && seen) begin
            $display("Unexpected memory write for file offset 0x%h", offset);
            error_count = error_count + 1;
        end else if (seen && exp_internal) begin
            check_value("conf_wr_o.wr", 32'(conf_wr.wr), 32'd1);
            check_value("mem_req_o.we", 32'(mem_req.we), 32'd0);
            check_value("conf_wr_o.addr", 32'(conf_wr.addr), 32'(exp_addr[15:0]));
            check_value("conf_wr_o.data", 32'(conf_wr.data), 32'(data));
        end else if (seen) begin
            check_value("mem_req_o.we", 32'(mem_req.we), 32'd1);
            check_value("conf_wr_o.wr", 32'(conf_wr.wr), 32'd0);
            check_value("mem_req_o.oe", 32'(mem_req.oe), 32'd0);
            check_value("mem_req_o.addr", 32'(mem_req.addr), 32'(exp_addr));
            check_value("mem_req_o.din", 32'(mem_req.din), 32'(data));
        end
        repeat (2) @(posedge clk_sys);
    endtask

    // Eight BASIC pointer writes, then the optional cartridge reset
    task automatic verify_pointer_writes(input logic [15:0] end_addr, input logic exp_reset);
        logic       seen;
        integer     cycles;
        logic [7:0] exp_data;
        for (int k = 0; k < 8; k++) begin
            seen   = 1'b0;
            cycles = 0;
            while (!seen && cycles < SEQ_TIMEOUT) begin
                @(negedge clk_sys);
                seen   = conf_wr.wr;
                cycles = cycles + 1;
            end
            exp_data = (k % 2 == 1) ? end_addr[15:8] : end_addr[7:0];
            if (!seen) begin
                $display("Timeout: BASIC pointer write %0d did not appear", k);
                timeout_count = timeout_count + 1;
            end else begin
                check_value("conf_wr_o.addr", 32'(conf_wr.addr), 32'(ptr_location(k)));
                check_value("conf_wr_o.data", 32'(conf_wr.data), 32'(exp_data));
                check_value("mem_req_o.we", 32'(mem_req.we), 32'd0);
            end
        end
        wait_core_reset(1'b1, seen);
        if (exp_reset && !seen) begin
            $display("Timeout: core reset did not follow the cartridge load");
            timeout_count = timeout_count + 1;
        end else if (!exp_reset && seen) begin
            $display("Core reset pulsed after a load that never reached $A000");
            error_count = error_count + 1;
        end
        if (seen) begin
            // Single-cycle pulse expected
            @(negedge clk_sys);
            check_value("core_reset_o", 32'(core_reset), 32'd0);
        end
    endtask

    task automatic run_rom();
        logic [31:0] rnd;
        logic [24:0] offset;
        logic [22:0] target;
        start_download(`DL_IDX_ROM, 1'b0);
        for (int i = 0; i < 32; i++) begin
            rnd    = $random(seed);
            offset = 25'h2000 + 25'(rnd[15:0] % 16'h6000);
            target = rom_target(offset);
            rnd    = $random(seed);
            send_byte(offset, rnd[7:0], 1'b1, target >= 23'h4000, target);
        end
        // Offsets below the kernal image are dropped
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            send_byte(25'(rnd[12:0]), rnd[20:13], 1'b0, 1'b0, 23'd0);
        end
        end_download();
        repeat (3) @(posedge clk_sys);
    endtask

    task automatic run_prg(input logic [7:0] index, input logic no_hdr,
                           input logic [15:0] header, input int nbytes);
        logic [31:0] rnd;
        logic [15:0] addr;
        logic [24:0] offset;
        logic        covered;
        start_download(index, no_hdr);
        offset  = '0;
        covered = 1'b0;
        if (no_hdr) begin
            addr = 16'hA000;
        end else begin
            send_byte(25'd0, header[7:0], 1'b0, 1'b0, 23'd0);
            send_byte(25'd1, header[15:8], 1'b0, 1'b0, 23'd0);
            addr   = header;
            offset = 25'd2;
        end
        for (int i = 0; i < nbytes; i++) begin
            rnd = $random(seed);
            send_byte(offset, rnd[7:0], 1'b1, prg_internal(addr), {7'd0, addr});
            if (addr == 16'hA000)
                covered = 1'b1;
            addr   = addr + 16'd1;
            offset = offset + 25'd1;
        end
        end_download();
        verify_pointer_writes(addr, covered);
    endtask

    task automatic run_tap(input int nbytes);
        logic [31:0] rnd;
        start_download(`DL_IDX_TAP, 1'b0);
        for (int i = 0; i < nbytes; i++) begin
            rnd = $random(seed);
            send_byte(25'(i), rnd[7:0], 1'b1, 1'b0, 23'h20000 + 23'(i));
        end
        end_download();
        repeat (3) @(posedge clk_sys);
    endtask

    // ============================================================
    // Cart unload and core pass-through
    // ============================================================

    task automatic run_cart_unload();
        logic seen;
        @(posedge clk_sys);
        cart_unload <= 1'b1;
        wait_core_reset(1'b1, seen);
        if (!seen) begin
            $display("Timeout: core reset did not rise on cart unload");
            timeout_count = timeout_count + 1;
        end
        check_value("mem_req_o.we", 32'(mem_req.we), 32'd1);
        check_value("mem_req_o.oe", 32'(mem_req.oe), 32'd0);
        check_value("mem_req_o.addr", 32'(mem_req.addr), 32'h0000A004);
        check_value("mem_req_o.din", 32'(mem_req.din), 32'h00);
        @(posedge clk_sys);
        cart_unload <= 1'b0;
        wait_core_reset(1'b0, seen);
        if (!seen) begin
            $display("Timeout: core reset stayed high after cart unload");
            timeout_count = timeout_count + 1;
        end
    endtask

    task automatic run_core_mirror();
        logic [31:0] rnd;
        for (int i = 0; i < 24; i++) begin
            rnd = $random(seed);
            @(posedge clk_sys);
            core_mem.sel  <= rnd[0];
            core_mem.wr_n <= rnd[1];
            core_mem.addr <= rnd[23:8];
            core_mem.data <= rnd[31:24];
            @(negedge clk_sys);
            check_value("mem_req_o.we", 32'(mem_req.we), 32'(rnd[0] && !rnd[1]));
            check_value("mem_req_o.oe", 32'(mem_req.oe), 32'(rnd[0] && rnd[1]));
            check_value("mem_req_o.addr", 32'(mem_req.addr), 32'(rnd[23:8]));
            check_value("mem_req_o.din", 32'(mem_req.din), 32'(rnd[31:24]));
        end
        @(posedge clk_sys);
        core_mem <= '0;
    endtask

    initial begin
        seed             = 9;
        error_count      = 0;
        timeout_count    = 0;
        assert_fails     = 0;
        clk_sys          = 1'b0;
        rst_i            = 1'b1;
        dl               = '0;
        crt_no_load_addr = 1'b0;
        cart_unload      = 1'b0;
        core_mem         = '0;

        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        check_value("core_reset_o", 32'(core_reset), 32'd1);
        check_value("conf_wr_o.wr", 32'(conf_wr.wr), 32'd0);
        check_value("mem_req_o.we", 32'(mem_req.we), 32'd0);
        check_value("mem_req_o.oe", 32'(mem_req.oe), 32'd0);
        @(posedge clk_sys);
        rst_i <= 1'b0;
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        check_value("core_reset_o", 32'(core_reset), 32'd0);

        run_rom();
        header_rnd = $random(seed);
        run_prg(`DL_IDX_PRG, 1'b0, header_rnd[15:0], 24);
        // Headers chosen to straddle the internal RAM edges and the cartridge base
        run_prg(`DL_IDX_PRG, 1'b0, 16'h03F8, 12);
        run_prg(`DL_IDX_PRG, 1'b0, 16'h0FFC, 8);
        run_prg(`DL_IDX_PRG, 1'b0, 16'h97FA, 10);
        run_prg(`DL_IDX_PRG, 1'b0, 16'h9FF4, 20);
        run_prg(`DL_IDX_CRT, 1'b1, 16'h0000, 16);
        run_tap(20);
        run_cart_unload();
        run_core_mirror();

        assert_fails = UUT.u_arbiter.u_assert.fail_count;
        $display("Value mismatches: %0d, timeouts: %0d, assertion failures: %0d",
                 error_count, timeout_count, assert_fails);
        if (error_count == 0 && timeout_count == 0 && assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
hdl/vic20_load_pkg.sv
hdl/load_addr_map.sv
hdl/prg_load_tracker.sv
hdl/basic_ptr_injector.sv
hdl/mem_port_arbiter.sv
hdl/vic20_loader_top.sv
bench/vic20_loader_assert.sv
bench/tb_vic20_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_vic20_loader -f files.f -o tb_vic20_loader

status=0
./obj_dir/tb_vic20_loader > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "All tests passed!" "$LOG"; then
    echo "Simulation did not complete"
    exit 1
fi
echo "Simulation PASSED"
